// File: include/beam_macros.svh
`ifndef BEAM_MACROS_SVH
`define BEAM_MACROS_SVH

// Array geometry
// Eight antennas, four samples each per clock
`define NCHAN 8
`define NSAMP 4
// Raw sample width, offset binary
`define NBITS 5
// Beams formed in parallel
`define NBEAMS 2

// Threshold register width
`define THRESH_W 18

// History depth in words, counting the word that arrives this clock
// Three words reach back far enough for delays of 0 to 8 samples
`define STORE_WORDS 3

// Delay in samples, indexed beam first and then channel
// Beam 0 is broadside, so every channel lines up as is
// Beam 1 steps one sample per channel across the array
`define BEAM_DELAYS '{'{0, 0, 0, 0, 0, 0, 0, 0}, '{0, 1, 2, 3, 4, 5, 6, 7}}

// Used channels per beam, bit n is channel n
// Beam 1 runs without channel 5
`define BEAM_USE '{8'hFF, 8'hDF}

// Inverted channels per beam, bit n is channel n
// Channels 2 and 6 have flipped polarity on beam 1
`define BEAM_INV '{8'h00, 8'h44}

`endif

// File: hdl/beam_pkg.sv
`default_nettype none

`include "beam_macros.svh"

package beam_pkg;

    // One raw sample, offset binary
    // Code 16 is zero signal
    typedef logic [`NBITS-1:0] sample_t;

    // Four samples of one channel
    // Sample 0 is the earliest and sits in the low bits
    typedef sample_t [`NSAMP-1:0] chan_word_t;

    // One clock of the whole array, channel 0 in the low bits
    // Also the shape of one beam's aligned data
    typedef chan_word_t [`NCHAN-1:0] array_word_t;

    // Sum of the four squared beam samples
    typedef logic [17:0] power_t;

    // Trigger threshold, compared against power_t
    typedef logic [`THRESH_W-1:0] thresh_t;

    // Beam select on the threshold path
    typedef logic [$clog2(`NBEAMS)-1:0] beam_idx_t;

endpackage

`default_nettype wire

// File: hdl/thresh_if.sv
`timescale 1ns/1ns
`default_nettype none

// Threshold write path from the loader into the beam unit
// wr_en is a single-cycle strobe and qualifies every other field
interface thresh_if
    import beam_pkg::*;
();

    // New value for the shadow register of wr_beam
    thresh_t   wr_val;
    beam_idx_t wr_beam;
    // Write strobe
    logic      wr_en;
    // Copy all shadows to the active set on this write
    logic      commit;

    // Loader side drives every field
    modport loader (output wr_val, output wr_beam, output wr_en, output commit);

    // Beam unit only listens
    modport beam (input wr_val, input wr_beam, input wr_en, input commit);

endinterface

`default_nettype wire

// File: hdl/sample_delay_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "beam_macros.svh"

// Short sample history per channel
// Cuts one delayed four-sample window per beam and channel out of it
module sample_delay_store
    import beam_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_i,
    // New word, sample 0 earliest
    input  wire array_word_t           data_i,
    // Aligned windows, one array word per beam
    output array_word_t [`NBEAMS-1:0]  beam_data_o
);

    // Registered part of the history in samples
    // The live input word is the newest word of the store
    localparam int HIST_S = (`STORE_WORDS - 1) * `NSAMP;
    // Full store in samples, live word included
    localparam int WIN_S  = `STORE_WORDS * `NSAMP;

    // Delay table, beam first then channel
    localparam int BEAM_D [`NBEAMS][`NCHAN] = `BEAM_DELAYS;

    // Offset-binary zero
    localparam sample_t MID_CODE = sample_t'(1 << (`NBITS - 1));

    // Older words per channel
    // Sample 0 is the oldest sample kept
    sample_t [HIST_S-1:0] hist_q [`NCHAN];
    // Whole store per channel, newest word on top
    sample_t [WIN_S-1:0]  win    [`NCHAN];

    for (genvar c = 0; c < `NCHAN; c++) begin : g_win
        // Incoming word stacked above the history
        assign win[c] = {data_i[c], hist_q[c]};
    end

    // History moves down by one word per clock
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int c = 0; c < `NCHAN; c++) begin
                // Offset zero, so an idle store reads as no signal
                hist_q[c] <= {HIST_S{MID_CODE}};
            end
        end else begin
            for (int c = 0; c < `NCHAN; c++) begin
                // Oldest word drops off the bottom
                hist_q[c] <= win[c][`NSAMP +: HIST_S];
            end
        end
    end

    // Window for delay d starts d samples below the live word
    // Output sample k is stream sample 4m+k-d of that channel
    // d of 0 picks the live word, d of 8 the oldest word
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < `NBEAMS; b++) begin
            for (int c = 0; c < `NCHAN; c++) begin
                beam_data_o[b][c] <= win[c][HIST_S - BEAM_D[b][c] +: `NSAMP];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/dual_beam_power.sv
`timescale 1ns/1ns
`default_nettype none

`include "beam_macros.svh"

// Two beams side by side
// Signed sum over channels, square, power sum and threshold compare
// Three register stages after the aligned input
module dual_beam_power
    import beam_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    // Aligned windows from the delay store
    input  wire array_word_t [`NBEAMS-1:0]  beam_data_i,
    // Threshold writes
    thresh_if.beam                          tif,
    // One trigger bit per beam
    output logic [`NBEAMS-1:0]              trigger_o
);

    // Channel use and polarity per beam, bit n is channel n
    localparam bit [`NCHAN-1:0] BEAM_U [`NBEAMS] = `BEAM_USE;
    localparam bit [`NCHAN-1:0] BEAM_I [`NBEAMS] = `BEAM_INV;

    // Beam sample width
    // Eight channels of -16..16 give -128..128
    localparam int SUM_W = 9;

    typedef logic signed [SUM_W-1:0] beam_samp_t;

    // Offset-binary zero as a signed value
    localparam beam_samp_t MID = beam_samp_t'(1 << (`NBITS - 1));

    // Stage 1, summed beam samples
    beam_samp_t sum_d    [`NBEAMS][`NSAMP];
    beam_samp_t sum_q    [`NBEAMS][`NSAMP];
    // Stage 2, squared beam samples
    power_t     sq_q     [`NBEAMS][`NSAMP];
    // Stage 3 input, power per beam
    power_t     power_d  [`NBEAMS];
    // Written one at a time over tif
    thresh_t    shadow_q [`NBEAMS];
    // Used by the compare
    thresh_t    active_q [`NBEAMS];

    // Offset binary to signed
    function automatic beam_samp_t centered(input sample_t s);
        return $signed({{(SUM_W - `NBITS){1'b0}}, s}) - MID;
    endfunction

    // Beamform each of the four sample positions
    always_comb begin
        for (int b = 0; b < `NBEAMS; b++) begin
            for (int k = 0; k < `NSAMP; k++) begin
                sum_d[b][k] = '0;
                for (int c = 0; c < `NCHAN; c++) begin
                    // Unused channels add nothing
                    if (BEAM_U[b][c]) begin
                        if (BEAM_I[b][c]) begin
                            // Flipped antenna
                            sum_d[b][k] = sum_d[b][k] - centered(beam_data_i[b][c][k]);
                        end else begin
                            sum_d[b][k] = sum_d[b][k] + centered(beam_data_i[b][c][k]);
                        end
                    end
                end
            end
        end
    end

    // Sum and square stages
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < `NBEAMS; b++) begin
            for (int k = 0; k < `NSAMP; k++) begin
                sum_q[b][k] <= sum_d[b][k];
                // Square of at most 128, formed at the 18-bit power width
                sq_q[b][k]  <= sum_q[b][k] * sum_q[b][k];
            end
        end
    end

    // Power over one clock's four samples
    // Four squares of at most 16384 stay inside 18 bits
    always_comb begin
        for (int b = 0; b < `NBEAMS; b++) begin
            power_d[b] = '0;
            for (int k = 0; k < `NSAMP; k++) begin
                power_d[b] = power_d[b] + sq_q[b][k];
            end
        end
    end

    // Compare stage, strictly above threshold fires
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            trigger_o <= '0;
        end else begin
            for (int b = 0; b < `NBEAMS; b++) begin
                trigger_o[b] <= (power_d[b] > active_q[b]);
            end
        end
    end

    // Shadow and active thresholds
    // All ones out of reset, out of reach of any power value
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int b = 0; b < `NBEAMS; b++) begin
                shadow_q[b] <= '1;
                active_q[b] <= '1;
            end
        end else if (tif.wr_en) begin
            shadow_q[tif.wr_beam] <= tif.wr_val;
            if (tif.commit) begin
                // Both beams switch together
                // The value written on this edge goes straight through
                for (int b = 0; b < `NBEAMS; b++) begin
                    if (beam_idx_t'(b) == tif.wr_beam) begin
                        active_q[b] <= tif.wr_val;
                    end else begin
                        active_q[b] <= shadow_q[b];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/thresh_loader.sv
`timescale 1ns/1ns
`default_nettype none

// Four-phase req/ack slave for threshold writes
// One write strobe per request, ack held until req drops
module thresh_loader
    import beam_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       thresh_req_i,
    output logic            thresh_ack_o,
    input  wire thresh_t    thresh_val_i,
    input  wire beam_idx_t  thresh_beam_i,
    input  wire logic       thresh_commit_i,
    thresh_if.loader        tif
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACKED,
        ST_RELEASE
    } state_t;

    state_t    state_q;
    logic      ack_q;
    logic      wr_en_q;
    // Request fields, held with the strobe
    thresh_t   val_q;
    beam_idx_t beam_q;
    logic      commit_q;
    // Request seen while waiting
    logic      take;

    assign take = (state_q == ST_IDLE) && thresh_req_i;

    // Handshake FSM
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            // Strobe lasts a single cycle
            wr_en_q <= take;
            case (state_q)
                ST_IDLE: begin
                    if (thresh_req_i) begin
                        ack_q   <= 1'b1;
                        state_q <= ST_ACKED;
                    end
                end
                ST_ACKED: begin
                    // Master finished, let go of ack
                    if (!thresh_req_i) begin
                        ack_q   <= 1'b0;
                        state_q <= ST_RELEASE;
                    end
                end
                // Turnaround cycle, a new req waits in idle
                ST_RELEASE: state_q <= ST_IDLE;
                default:    state_q <= ST_IDLE;
            endcase
        end
    end

    // Master holds the fields stable while req is high
    always_ff @(posedge clk_i) begin
        if (take) begin
            val_q    <= thresh_val_i;
            beam_q   <= thresh_beam_i;
            commit_q <= thresh_commit_i;
        end
    end

    assign thresh_ack_o = ack_q;

    assign tif.wr_en   = wr_en_q;
    assign tif.wr_val  = val_q;
    assign tif.wr_beam = beam_q;
    assign tif.commit  = commit_q;

endmodule

`default_nettype wire

// File: hdl/beam_trigger_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "beam_macros.svh"

// Two-beam trigger
// Delay store, threshold loader and dual beam unit
// Four clocks from data_i to trigger_o
module beam_trigger_top
    import beam_pkg::*;
(
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    // Eight channels, four samples each per clock
    input  wire array_word_t          data_i,
    // Threshold port, four-phase req/ack
    input  wire logic                 thresh_req_i,
    output wire logic                 thresh_ack_o,
    input  wire thresh_t              thresh_val_i,
    input  wire beam_idx_t            thresh_beam_i,
    input  wire logic                 thresh_commit_i,
    // One bit per beam
    output wire logic [`NBEAMS-1:0]   trigger_o
);

    // Aligned windows per beam
    array_word_t [`NBEAMS-1:0] beam_data;

    // Threshold writes from loader to beam unit
    thresh_if tif ();

    // History and per-beam delay alignment
    sample_delay_store u_store (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .data_i      (data_i),
        .beam_data_o (beam_data)
    );

    // External handshake to single-cycle writes
    thresh_loader u_loader (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .thresh_req_i    (thresh_req_i),
        .thresh_ack_o    (thresh_ack_o),
        .thresh_val_i    (thresh_val_i),
        .thresh_beam_i   (thresh_beam_i),
        .thresh_commit_i (thresh_commit_i),
        .tif             (tif.loader)
    );

    // Sum, square, power and compare
    dual_beam_power u_beams (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .beam_data_i (beam_data),
        .tif         (tif.beam),
        .trigger_o   (trigger_o)
    );

endmodule

`default_nettype wire

// File: tb/beam_trigger_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "beam_macros.svh"

module beam_trigger_tb
    import beam_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY = 5;
    // Test cycles of all tests together, then slack for the handshakes
    localparam int TEST_CYCLES = 750;
    localparam int MARGIN_CYCLES = 250;
    localparam int SEED = 32'h4822;

    // Beam tables from the shared definitions
    localparam int BEAM_D [`NBEAMS][`NCHAN] = `BEAM_DELAYS;
    localparam bit [`NCHAN-1:0] BEAM_U [`NBEAMS] = `BEAM_USE;
    localparam bit [`NCHAN-1:0] BEAM_I [`NBEAMS] = `BEAM_INV;

    localparam int MODE_IDLE = 0;
    localparam int MODE_RAND = 1;
    localparam int MODE_PULSE = 2;
    localparam int MODE_PATTERN = 3;
    localparam sample_t MID_CODE = sample_t'(16);

    logic clk_i = 1'b0;
    logic rst_i;
    array_word_t data_i;
    logic thresh_req_i;
    logic thresh_ack_o;
    thresh_t thresh_val_i;
    beam_idx_t thresh_beam_i;
    logic thresh_commit_i;
    logic [`NBEAMS-1:0] trigger_o;

    // Stimulus control
    int data_mode = MODE_IDLE;
    bit pulse_pending = 1'b0;
    int pulse_chan = 0;
    int pulse_pos = 0;
    logic chk_en = 1'b0;

    // Reference model, history index 0 is the newest sample
    int hist_m [`NCHAN][12];
    int pipe_m [3][`NBEAMS];
    thresh_t shadow_m [`NBEAMS];
    thresh_t act_m [`NBEAMS];
    logic [`NBEAMS-1:0] exp_trig;
    logic exp_ack;
    logic exp_wr;
    int lstate_m;
    thresh_t pend_val;
    beam_idx_t pend_beam;
    logic pend_commit;

    // Bookkeeping
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_mark;
    int trig_cnt [`NBEAMS];
    int wr_cnt = 0;
    int req_cnt = 0;
    string cur_test;

    beam_trigger_top UUT (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .data_i          (data_i),
        .thresh_req_i    (thresh_req_i),
        .thresh_ack_o    (thresh_ack_o),
        .thresh_val_i    (thresh_val_i),
        .thresh_beam_i   (thresh_beam_i),
        .thresh_commit_i (thresh_commit_i),
        .trigger_o       (trigger_o)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Power of one beam over the newest window in the model history
    function automatic int beam_power(input int b);
        int sum;
        int pwr;
        pwr = 0;
        for (int k = 0; k < `NSAMP; k++) begin
            sum = 0;
            for (int c = 0; c < `NCHAN; c++) begin
                if (BEAM_U[b][c] && BEAM_I[b][c]) begin
                    sum -= hist_m[c][3 - k + BEAM_D[b][c]] - 16;
                end else if (BEAM_U[b][c]) begin
                    sum += hist_m[c][3 - k + BEAM_D[b][c]] - 16;
                end
            end
            pwr += sum * sum;
        end
        return pwr;
    endfunction

    // Model steps on the same edges as the DUT
    always @(posedge clk_i) begin
        if (rst_i) begin
            for (int c = 0; c < `NCHAN; c++) begin
                for (int j = 0; j < 12; j++) hist_m[c][j] = 16;
            end
            for (int b = 0; b < `NBEAMS; b++) begin
                for (int s = 0; s < 3; s++) pipe_m[s][b] = 0;
                shadow_m[b] = '1;
                act_m[b] = '1;
            end
            exp_trig = '0;
            exp_ack = 1'b0;
            exp_wr = 1'b0;
            lstate_m = 0;
        end else begin
            // Compare against thresholds of the previous cycle
            for (int b = 0; b < `NBEAMS; b++) begin
                exp_trig[b] = pipe_m[2][b] > int'(act_m[b]);
            end
            // Write strobed last cycle, commit copies shadows incl. the new one
            if (exp_wr) begin
                shadow_m[pend_beam] = pend_val;
                if (pend_commit) act_m = shadow_m;
            end
            exp_wr = (lstate_m == 0) && thresh_req_i;
            if (exp_wr) begin
                pend_val = thresh_val_i;
                pend_beam = thresh_beam_i;
                pend_commit = thresh_commit_i;
            end
            // Handshake idle, acked, release
            case (lstate_m)
                0: if (thresh_req_i) begin
                    exp_ack = 1'b1;
                    lstate_m = 1;
                end
                1: if (!thresh_req_i) begin
                    exp_ack = 1'b0;
                    lstate_m = 2;
                end
                default: lstate_m = 0;
            endcase
            for (int c = 0; c < `NCHAN; c++) begin
                for (int j = 11; j >= 4; j--) hist_m[c][j] = hist_m[c][j - 4];
                for (int k = 0; k < `NSAMP; k++) hist_m[c][3 - k] = int'(data_i[c][k]);
            end
            for (int b = 0; b < `NBEAMS; b++) begin
                pipe_m[2][b] = pipe_m[1][b];
                pipe_m[1][b] = pipe_m[0][b];
                pipe_m[0][b] = beam_power(b);
            end
        end
    end

    // Data driver, control sampled on the edge and applied after the delay
    always @(posedge clk_i) begin
        int mode;
        bit do_pulse;
        mode = data_mode;
        do_pulse = pulse_pending;
        #DRIVE_DLY;
        for (int c = 0; c < `NCHAN; c++) begin
            for (int k = 0; k < `NSAMP; k++) begin
                case (mode)
                    MODE_RAND: data_i[c][k] = sample_t'($urandom);
                    // +12 on channels 2 and 6, -4 elsewhere
                    MODE_PATTERN: data_i[c][k] = (c == 2 || c == 6) ? 5'd28 : 5'd12;
                    default: data_i[c][k] = MID_CODE;
                endcase
            end
        end
        if (mode == MODE_PULSE && do_pulse) begin
            data_i[pulse_chan][pulse_pos] = 5'd31;
            pulse_pending = 1'b0;
        end
    end

    always @(negedge clk_i) begin
        if (chk_en && trigger_o[0]) trig_cnt[0]++;
        if (chk_en && trigger_o[1]) trig_cnt[1]++;
        if (!rst_i && UUT.tif.wr_en) wr_cnt++;
    end

    trigger_match: assert property (@(negedge clk_i) disable iff (!chk_en)
        trigger_o == exp_trig) else begin
        errors++;
        $display("FAILED %0t: trigger_o %b, model %b", $time, trigger_o, exp_trig);
    end

    ack_match: assert property (@(negedge clk_i) disable iff (rst_i)
        thresh_ack_o == exp_ack) else begin
        errors++;
        $display("FAILED %0t: thresh_ack_o %b, model %b", $time, thresh_ack_o, exp_ack);
    end

    write_match: assert property (@(negedge clk_i) disable iff (rst_i)
        UUT.tif.wr_en == exp_wr) else begin
        errors++;
        $display("FAILED %0t: wr_en %b, model %b", $time, UUT.tif.wr_en, exp_wr);
    end

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #DRIVE_DLY;
        end
    endtask

    // Master side of the four-phase handshake
    task automatic write_thresh(input int b, input int val, input bit commit, input int hold);
        thresh_beam_i = beam_idx_t'(b);
        thresh_val_i = thresh_t'(val);
        thresh_commit_i = commit;
        thresh_req_i = 1'b1;
        do wait_cycles(1); while (!thresh_ack_o);
        wait_cycles(hold);
        thresh_req_i = 1'b0;
        do wait_cycles(1); while (thresh_ack_o);
        req_cnt++;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
        trig_cnt[0] = 0;
        trig_cnt[1] = 0;
    endtask

    task automatic require(input bit ok, input string what);
        assert (ok) else begin
            errors++;
            $display("FAILED %0t: test %s, %s", $time, cur_test, what);
        end
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("Test %-10s %s, %0d errors, triggers %0d/%0d", cur_test,
                 (errors == err_mark) ? "ok" : "bad", errors - err_mark,
                 trig_cnt[0], trig_cnt[1]);
    endtask

    initial begin
        int wr_mark;
        void'($urandom(SEED));
        rst_i = 1'b1;
        data_i = {(`NCHAN * `NSAMP){MID_CODE}};
        thresh_req_i = 1'b0;
        thresh_val_i = '0;
        thresh_beam_i = '0;
        thresh_commit_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #DRIVE_DLY;
        rst_i = 1'b0;
        wait_cycles(4);
        chk_en = 1'b1;

        begin_test("reset");
        data_mode = MODE_RAND;
        wait_cycles(40);
        require(trig_cnt[0] == 0 && trig_cnt[1] == 0, "trigger seen at default thresholds");
        end_test();

        begin_test("commit");
        write_thresh(0, 2500, 1'b0, 0);
        wait_cycles(10);
        write_thresh(1, 2000, 1'b1, 0);
        wait_cycles(60);
        require(trig_cnt[0] > 0 && trig_cnt[1] > 0, "random data never triggered");
        end_test();

        data_mode = MODE_IDLE;
        wait_cycles(6);
        write_thresh(0, 200, 1'b0, 0);
        write_thresh(1, 200, 1'b1, 0);
        begin_test("pulse");
        data_mode = MODE_PULSE;
        for (int c = 0; c < `NCHAN; c++) begin
            pulse_chan = c;
            pulse_pos = c % `NSAMP;
            pulse_pending = 1'b1;
            wait_cycles(10);
        end
        // Channel 5 is unused on beam 1
        require(trig_cnt[0] == 8 && trig_cnt[1] == 7, "wrong number of pulse triggers");
        end_test();

        data_mode = MODE_IDLE;
        wait_cycles(6);
        write_thresh(0, 1000, 1'b0, 0);
        write_thresh(1, 1000, 1'b1, 0);
        begin_test("invert");
        data_mode = MODE_PATTERN;
        wait_cycles(20);
        data_mode = MODE_IDLE;
        wait_cycles(8);
        require(trig_cnt[0] == 0 && trig_cnt[1] > 0, "pattern did not cancel on beam 0 only");
        end_test();

        begin_test("handshake");
        wr_mark = wr_cnt - req_cnt;
        for (int h = 0; h < 4; h++) write_thresh(h % 2, 262143, h[0], h);
        wait_cycles(2);
        require(wr_cnt - req_cnt == wr_mark, "write count differs from request count");
        end_test();

        begin_test("random");
        write_thresh(0, $urandom_range(3500, 1500), 1'b0, 0);
        write_thresh(1, $urandom_range(3000, 1200), 1'b1, 1);
        data_mode = MODE_RAND;
        wait_cycles(400);
        end_test();

        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog for a hung handshake
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
hdl/beam_pkg.sv
hdl/thresh_if.sv
hdl/sample_delay_store.sv
hdl/dual_beam_power.sv
hdl/thresh_loader.sv
hdl/beam_trigger_top.sv
tb/beam_trigger_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the beam trigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f flist.f --top-module beam_trigger_tb -o beam_trigger_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/beam_trigger_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "No pass message in $LOG"
    exit 1
fi
exit 0
